// File: source/hough_pkg.sv
package hough_pkg;

    // Image geometry and the scan window inside it
    localparam int IMAGE_WIDTH = 16;
    localparam int IMAGE_HEIGHT = 16;
    localparam int PIXEL_ADDR_WIDTH = 8;
    localparam int SCAN_MARGIN = 1;
    localparam int SCAN_LAST_X = IMAGE_WIDTH - 1 - SCAN_MARGIN;
    localparam int SCAN_LAST_Y = IMAGE_HEIGHT - 1 - SCAN_MARGIN;
    localparam logic [7:0] MASK_MIN = 8'h0F;

    // Theta bins are split evenly across the vote lanes
    localparam int THETA_COUNT = 12;
    localparam int THETA_STEP_DEG = 15;
    localparam int LANE_COUNT = 4;
    localparam int STEPS_PER_LANE = 3;

    // Trig values scaled by 2^7 and rounded to nearest
    localparam int TRIG_FRAC_BITS = 7;
    localparam logic signed [8:0] COS_TABLE [THETA_COUNT] = '{
        128, 124, 111, 91, 64, 33, 0, -33, -64, -91, -111, -124
    };
    localparam logic signed [8:0] SIN_TABLE [THETA_COUNT] = '{
        0, 33, 64, 91, 111, 124, 128, 124, 111, 91, 64, 33
    };

    // Rho runs from -22 to 22 once shifted into a bin index
    localparam int RHO_OFFSET = 22;
    localparam int RHO_BINS = 45;
    localparam int ACCUM_WIDTH = 4;
    localparam int VOTE_THRESHOLD = 6;
    localparam int LEFT_MIN_DEG = 100;
    localparam int RIGHT_MAX_DEG = 80;

    // Each lane bank holds one word per rho bin and theta step
    localparam int BANK_DEPTH = RHO_BINS * STEPS_PER_LANE;
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);

    typedef logic [PIXEL_ADDR_WIDTH-1:0] pixel_addr_t;
    typedef logic signed [5:0] coord_t;
    typedef logic [1:0] step_t;
    typedef logic [5:0] rho_bin_t;
    typedef logic [ACCUM_WIDTH-1:0] count_t;
    typedef logic [9:0] line_count_t;
    typedef logic signed [15:0] rho_sum_t;
    typedef logic [17:0] theta_sum_t;
    typedef enum logic [1:0] {IDLE, CLEAR, VOTE, SWEEP} vote_mode_t;
    typedef count_t [LANE_COUNT-1:0] lane_counts_t;

endpackage

// File: source/vote_bus_if.sv
`timescale 1ns/1ns

// Command bus from the sequencer to the vote lanes and the line selector
interface vote_bus_if;

    // Current phase of the frame
    hough_pkg::vote_mode_t mode;

    // Pixel coordinates of the vote being cast
    hough_pkg::coord_t x;
    hough_pkg::coord_t y;

    // Theta step inside each lane, and the rho row for clear and sweep
    hough_pkg::step_t step;
    hough_pkg::rho_bin_t rho_bin;

    modport sequencer (output mode, x, y, step, rho_bin);

    modport lane (input mode, x, y, step, rho_bin);

    // The selector only needs to know which bin a swept count came from
    modport selector (input mode, step, rho_bin);

endinterface

// File: source/pixel_scanner.sv
`timescale 1ns/1ns

module pixel_scanner (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    output hough_pkg::pixel_addr_t  pixel_addr,
    input  logic [7:0]              edge_data,
    input  logic [7:0]              mask_data,
    vote_bus_if.sequencer           cmd,
    output logic                    sweep_done
);

    typedef enum logic [2:0] {
        S_CLEAR, S_IDLE, S_CHECK, S_VOTE, S_DRAIN, S_SWEEP, S_FINISH
    } state_t;

    state_t state;
    hough_pkg::coord_t x, y, next_x, next_y, fetch_x, fetch_y;
    hough_pkg::step_t step;
    hough_pkg::rho_bin_t row;
    logic last_pixel, last_step, last_entry, pixel_votes;

    // The pixel after the current one, wrapping to the window start after the last
    assign last_pixel = (x == hough_pkg::SCAN_LAST_X) && (y == hough_pkg::SCAN_LAST_Y);
    assign next_x = (x == hough_pkg::SCAN_LAST_X) ? hough_pkg::coord_t'(hough_pkg::SCAN_MARGIN)
                                                  : hough_pkg::coord_t'(x + 1'b1);
    assign next_y = (x != hough_pkg::SCAN_LAST_X) ? y
                  : (y == hough_pkg::SCAN_LAST_Y) ? hough_pkg::coord_t'(hough_pkg::SCAN_MARGIN)
                                                  : hough_pkg::coord_t'(y + 1'b1);
    assign last_step = (step == hough_pkg::step_t'(hough_pkg::STEPS_PER_LANE - 1));
    assign last_entry = last_step && (row == hough_pkg::rho_bin_t'(hough_pkg::RHO_BINS - 1));
    assign pixel_votes = (edge_data != 8'h00) && (mask_data >= hough_pkg::MASK_MIN);

    // While a frame runs the memory is always one pixel ahead of x and y
    // Outside a frame it already reads the first pixel so start costs nothing
    always_comb begin
        if (state == S_CHECK || state == S_VOTE || state == S_DRAIN) begin
            fetch_x = next_x;
            fetch_y = next_y;
        end else begin
            fetch_x = hough_pkg::coord_t'(hough_pkg::SCAN_MARGIN);
            fetch_y = hough_pkg::coord_t'(hough_pkg::SCAN_MARGIN);
        end
        pixel_addr = hough_pkg::pixel_addr_t'(fetch_y)
                       * hough_pkg::pixel_addr_t'(hough_pkg::IMAGE_WIDTH)
                   + hough_pkg::pixel_addr_t'(fetch_x);
        case (state)
            S_CLEAR: cmd.mode = hough_pkg::CLEAR;
            S_VOTE:  cmd.mode = hough_pkg::VOTE;
            S_SWEEP: cmd.mode = hough_pkg::SWEEP;
            default: cmd.mode = hough_pkg::IDLE;
        endcase
    end

    assign cmd.x = x;
    assign cmd.y = y;
    assign cmd.step = step;
    assign cmd.rho_bin = row;
    assign sweep_done = (state == S_FINISH);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= S_CLEAR;
            x <= hough_pkg::coord_t'(hough_pkg::SCAN_MARGIN);
            y <= hough_pkg::coord_t'(hough_pkg::SCAN_MARGIN);
            step <= '0;
            row <= '0;
        end else begin
            case (state)
                // Clear and sweep walk every bank word with step as the inner count
                S_CLEAR, S_SWEEP: begin
                    step <= last_step ? '0 : hough_pkg::step_t'(step + 1'b1);
                    row <= last_entry ? '0
                         : last_step ? hough_pkg::rho_bin_t'(row + 1'b1) : row;
                    if (last_entry) state <= (state == S_CLEAR) ? S_IDLE : S_FINISH;
                end
                // A start during clear or during a frame is simply not looked at
                S_IDLE: if (start) state <= S_CHECK;
                S_CHECK: begin
                    // A pixel without a vote moves on at once, the last one wraps to the start
                    if (pixel_votes) begin
                        state <= S_VOTE;
                    end else begin
                        if (last_pixel) begin
                            state <= S_SWEEP;
                        end
                        x <= next_x;
                        y <= next_y;
                    end
                end
                S_VOTE: begin
                    step <= last_step ? '0 : hough_pkg::step_t'(step + 1'b1);
                    if (last_step) state <= S_DRAIN;
                end
                // The lanes commit the last theta step while this cycle runs
                S_DRAIN: begin
                    state <= last_pixel ? S_SWEEP : S_CHECK;
                    x <= next_x;
                    y <= next_y;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // A start that arrives while busy must never restart the scan at the first pixel
    assert property (@(posedge clock) disable iff (reset)
        (start && state != S_IDLE) |=> !(state == S_CHECK && x == hough_pkg::SCAN_MARGIN
                                         && y == hough_pkg::SCAN_MARGIN && $past(state) != S_CHECK));

    // Reads stay inside the margin-trimmed window of the image
    assert property (@(posedge clock) disable iff (reset)
        (pixel_addr % hough_pkg::IMAGE_WIDTH)
            inside {[hough_pkg::SCAN_MARGIN:hough_pkg::SCAN_LAST_X]}
        && (pixel_addr / hough_pkg::IMAGE_WIDTH)
            inside {[hough_pkg::SCAN_MARGIN:hough_pkg::SCAN_LAST_Y]});

endmodule

// File: source/vote_lane.sv
`timescale 1ns/1ns

module vote_lane #(
    parameter int lane_index = 0
) (
    input  logic                clock,
    vote_bus_if.lane            cmd,
    output hough_pkg::count_t   count
);

    hough_pkg::count_t bank [hough_pkg::BANK_DEPTH];
    logic [hough_pkg::BANK_ADDR_WIDTH-1:0] rd_addr, wr_addr;
    hough_pkg::count_t rd_count, wr_count, sat_count;
    logic wr_en;
    int theta;
    logic signed [15:0] rho_acc, rho_full;
    hough_pkg::rho_bin_t row;

    always_comb begin
        // This lane owns a fixed run of theta bins picked by the step
        theta = lane_index * hough_pkg::STEPS_PER_LANE + int'(cmd.step);
        // Fixed-point rho with an arithmetic shift so negative values floor
        rho_acc = cmd.x * hough_pkg::COS_TABLE[theta] + cmd.y * hough_pkg::SIN_TABLE[theta];
        rho_full = rho_acc >>> hough_pkg::TRIG_FRAC_BITS;
        // Votes address the bin of their own rho, clear and sweep take the row from the bus
        if (cmd.mode == hough_pkg::VOTE) begin
            row = hough_pkg::rho_bin_t'(rho_full + hough_pkg::RHO_OFFSET);
        end else begin
            row = cmd.rho_bin;
        end
        rd_addr = hough_pkg::BANK_ADDR_WIDTH'(row)
                    * hough_pkg::BANK_ADDR_WIDTH'(hough_pkg::STEPS_PER_LANE)
                + hough_pkg::BANK_ADDR_WIDTH'(cmd.step);
        rd_count = bank[rd_addr];
        // Counts stick at the top value instead of wrapping
        sat_count = (rd_count == '1) ? rd_count : hough_pkg::count_t'(rd_count + 1'b1);
    end

    // Read now, write back one cycle later
    // Clear and sweep both leave zero behind so the next frame starts empty
    always_ff @(posedge clock) begin
        wr_en <= (cmd.mode != hough_pkg::IDLE);
        wr_addr <= rd_addr;
        wr_count <= (cmd.mode == hough_pkg::VOTE) ? sat_count : '0;
        if (cmd.mode == hough_pkg::SWEEP) begin
            count <= rd_count;
        end
        if (wr_en) begin
            bank[wr_addr] <= wr_count;
        end
    end

    // The trig tables and the scan window must keep every vote inside the bank
    assert property (@(posedge clock) (cmd.mode == hough_pkg::VOTE) |->
        (rho_full + hough_pkg::RHO_OFFSET >= 0)
        && (rho_full + hough_pkg::RHO_OFFSET < hough_pkg::RHO_BINS));

    // The sequencer order keeps the pending write off a word that a vote or a sweep reads
    // Clear rewrites its first word while reset holds the sequencer, which does no harm
    assert property (@(posedge clock)
        (wr_en && cmd.mode inside {hough_pkg::VOTE, hough_pkg::SWEEP}) |-> (wr_addr != rd_addr));

endmodule

// File: source/line_selector.sv
`timescale 1ns/1ns

module line_selector (
    input  logic                        clock,
    input  logic                        reset,
    vote_bus_if.selector                cmd,
    input  hough_pkg::lane_counts_t     counts,
    input  logic                        sweep_done,
    output logic                        done,
    output hough_pkg::line_count_t      left_count,
    output hough_pkg::line_count_t      right_count,
    output hough_pkg::rho_sum_t         left_rho_sum,
    output hough_pkg::rho_sum_t         right_rho_sum,
    output hough_pkg::theta_sum_t       left_theta_sum,
    output hough_pkg::theta_sum_t       right_theta_sum
);

    logic taking, first_take;
    hough_pkg::step_t step_q;
    hough_pkg::rho_bin_t row_q;
    hough_pkg::line_count_t left_add_count, right_add_count;
    hough_pkg::rho_sum_t line_rho, left_add_rho, right_add_rho;
    hough_pkg::theta_sum_t line_theta, left_add_theta, right_add_theta;

    // Bin position of the counts that the lanes return in the next cycle
    always_ff @(posedge clock) begin
        step_q <= cmd.step;
        row_q <= cmd.rho_bin;
    end

    // Every lane shares the same rho row, only theta differs between them
    always_comb begin
        left_add_count = '0;
        right_add_count = '0;
        left_add_rho = '0;
        right_add_rho = '0;
        left_add_theta = '0;
        right_add_theta = '0;
        line_theta = '0;
        line_rho = hough_pkg::rho_sum_t'(row_q) - hough_pkg::rho_sum_t'(hough_pkg::RHO_OFFSET);
        for (int k = 0; k < hough_pkg::LANE_COUNT; k++) begin
            line_theta = hough_pkg::theta_sum_t'((k * hough_pkg::STEPS_PER_LANE + int'(step_q))
                                                 * hough_pkg::THETA_STEP_DEG);
            if (counts[k] >= hough_pkg::VOTE_THRESHOLD) begin
                // Near-horizontal lines between the two limits belong to neither side
                if (line_theta > hough_pkg::LEFT_MIN_DEG) begin
                    left_add_count = left_add_count + 1'b1;
                    left_add_rho = left_add_rho + line_rho;
                    left_add_theta = left_add_theta + line_theta;
                end else if (line_theta < hough_pkg::RIGHT_MAX_DEG) begin
                    right_add_count = right_add_count + 1'b1;
                    right_add_rho = right_add_rho + line_rho;
                    right_add_theta = right_add_theta + line_theta;
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            taking <= 1'b0;
            first_take <= 1'b0;
            done <= 1'b0;
            left_count <= '0;
            right_count <= '0;
            left_rho_sum <= '0;
            right_rho_sum <= '0;
            left_theta_sum <= '0;
            right_theta_sum <= '0;
        end else begin
            taking <= (cmd.mode == hough_pkg::SWEEP);
            first_take <= (cmd.mode == hough_pkg::SWEEP) && (cmd.rho_bin == '0) && (cmd.step == '0);
            done <= sweep_done;
            // The first swept word replaces the totals of the previous frame
            if (taking) begin
                left_count <= (first_take ? '0 : left_count) + left_add_count;
                right_count <= (first_take ? '0 : right_count) + right_add_count;
                left_rho_sum <= (first_take ? '0 : left_rho_sum) + left_add_rho;
                right_rho_sum <= (first_take ? '0 : right_rho_sum) + right_add_rho;
                left_theta_sum <= (first_take ? '0 : left_theta_sum) + left_add_theta;
                right_theta_sum <= (first_take ? '0 : right_theta_sum) + right_add_theta;
            end
        end
    end

    // Done only follows a finished sweep, so no count is still on its way
    assert property (@(posedge clock) disable iff (reset) done |-> !taking && $past(taking, 2));

endmodule

// File: source/hough_lane_finder.sv
`timescale 1ns/1ns

module hough_lane_finder (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,
    output hough_pkg::pixel_addr_t      pixel_addr,
    input  logic [7:0]                  edge_data,
    input  logic [7:0]                  mask_data,
    output logic                        done,
    output hough_pkg::line_count_t      left_count,
    output hough_pkg::line_count_t      right_count,
    output hough_pkg::rho_sum_t         left_rho_sum,
    output hough_pkg::rho_sum_t         right_rho_sum,
    output hough_pkg::theta_sum_t       left_theta_sum,
    output hough_pkg::theta_sum_t       right_theta_sum
);

    hough_pkg::lane_counts_t lane_counts;
    logic sweep_done;

    // One command bus fans out from the sequencer to all lanes and the selector
    vote_bus_if vote_bus ();

    pixel_scanner pixel_scanner_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .pixel_addr (pixel_addr),
        .edge_data  (edge_data),
        .mask_data  (mask_data),
        .cmd        (vote_bus.sequencer),
        .sweep_done (sweep_done)
    );

    // Each lane votes for its own run of theta bins in parallel
    for (genvar k = 0; k < hough_pkg::LANE_COUNT; k++) begin : g_lane
        vote_lane #(
            .lane_index (k)
        ) vote_lane_inst (
            .clock (clock),
            .cmd   (vote_bus.lane),
            .count (lane_counts[k])
        );
    end

    line_selector line_selector_inst (
        .clock           (clock),
        .reset           (reset),
        .cmd             (vote_bus.selector),
        .counts          (lane_counts),
        .sweep_done      (sweep_done),
        .done            (done),
        .left_count      (left_count),
        .right_count     (right_count),
        .left_rho_sum    (left_rho_sum),
        .right_rho_sum   (right_rho_sum),
        .left_theta_sum  (left_theta_sum),
        .right_theta_sum (right_theta_sum)
    );

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ns

// Free-running 40 ns clock and a reset held for the first three cycles
module clock_gen #(
    parameter int half_period = 20,
    parameter int reset_cycles = 3
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Reset drops a little after an edge, like every other driven input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #5;
        reset = 1'b0;
    end

endmodule

// File: testbench/tb_frames.svh
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

    typedef enum logic [1:0] {FRAME_EMPTY, FRAME_COLUMN, FRAME_RANDOM, FRAME_REPEAT} frame_kind_t;

    // One test frame with its expected results
    // A repeat row keeps the memory of the row before it
    typedef struct packed {
        frame_kind_t kind;
        logic [4:0] density;
        logic [3:0] col;
        logic [3:0] x_lo;
        logic [3:0] x_hi;
        logic [3:0] y_lo;
        logic [3:0] y_hi;
        logic use_model;
        hough_pkg::line_count_t left_count;
        hough_pkg::line_count_t right_count;
        hough_pkg::rho_sum_t left_rho;
        hough_pkg::rho_sum_t right_rho;
        hough_pkg::theta_sum_t left_theta;
        hough_pkg::theta_sum_t right_theta;
    } frame_row_t;

    localparam int FRAME_ROWS = 7;
    localparam int COUNT_MAX = (1 << hough_pkg::ACCUM_WIDTH) - 1;

    // Noise density is out of 16, the mask window is x_lo..x_hi by y_lo..y_hi
    // An empty window (lo above hi) masks out the whole image
    localparam frame_row_t frame_table [FRAME_ROWS] = '{
        // kind         dens col x_lo x_hi y_lo y_hi model, then explicit expected values
        '{FRAME_EMPTY,    0,  0,  0,  15,  0,  15,  0,    0, 0, 0, 0, 0, 0},
        '{FRAME_COLUMN,   0,  4,  0,  15,  0,  15,  1,    0, 0, 0, 0, 0, 0},
        '{FRAME_COLUMN,   0, 11,  0,  15,  1,   7,  1,    0, 0, 0, 0, 0, 0},
        '{FRAME_RANDOM,   6,  0, 15,   0, 15,   0,  0,    0, 0, 0, 0, 0, 0},
        '{FRAME_RANDOM,  14,  0,  0,  15,  0,  15,  1,    0, 0, 0, 0, 0, 0},
        '{FRAME_REPEAT,   0,  0,  0,   0,  0,   0,  1,    0, 0, 0, 0, 0, 0},
        '{FRAME_COLUMN,   2,  7,  3,  12,  3,  12,  1,    0, 0, 0, 0, 0, 0}
    };

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    logic [15:0] lfsr_state = 16'd57725;

    // Takes one bit per step, oldest bit first in the result
    function automatic logic [7:0] random_bits(input int width);
        logic [7:0] bits;
        bits = 8'h00;
        for (int i = 0; i < width; i++) begin
            bits = {bits[6:0], lfsr_state[15]};
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        end
        return bits;
    endfunction

    // Fills both host memories, border pixels included, from one table row
    task automatic build_frame(input frame_row_t row);
        int x;
        int y;
        logic [7:0] edge_val;
        logic in_window;
        for (int a = 0; a < hough_pkg::IMAGE_WIDTH * hough_pkg::IMAGE_HEIGHT; a++) begin
            x = a % hough_pkg::IMAGE_WIDTH;
            y = a / hough_pkg::IMAGE_WIDTH;
            edge_val = 8'h00;
            if (random_bits(4) < row.density) begin
                edge_val = random_bits(8) | 8'h01;
            end
            if (row.kind == FRAME_COLUMN && x == row.col) begin
                edge_val = 8'hFF;
            end
            in_window = (x >= row.x_lo) && (x <= row.x_hi) && (y >= row.y_lo) && (y <= row.y_hi);
            edge_mem[a] = edge_val;
            // Mask bytes sit at or just below the limit, varied over the address
            if (in_window) begin
                mask_mem[a] = hough_pkg::MASK_MIN + 8'(a % 7);
            end else begin
                mask_mem[a] = hough_pkg::MASK_MIN - 8'd1 - 8'(a % 7);
            end
        end
    endtask

    // Reference Hough transform over the trimmed window with saturating bins
    task automatic model_frame(output hough_pkg::line_count_t left_n,
                               output hough_pkg::line_count_t right_n,
                               output hough_pkg::rho_sum_t left_rho,
                               output hough_pkg::rho_sum_t right_rho,
                               output hough_pkg::theta_sum_t left_theta,
                               output hough_pkg::theta_sum_t right_theta);
        int votes [hough_pkg::THETA_COUNT][hough_pkg::RHO_BINS];
        int a;
        int product;
        int rho;
        int theta;
        int ln;
        int rn;
        int lr;
        int rr;
        int lt;
        int rt;
        foreach (votes[t, b]) begin
            votes[t][b] = 0;
        end
        for (int y = hough_pkg::SCAN_MARGIN; y < hough_pkg::IMAGE_HEIGHT - hough_pkg::SCAN_MARGIN;
             y++) begin
            for (int x = hough_pkg::SCAN_MARGIN; x < hough_pkg::IMAGE_WIDTH - hough_pkg::SCAN_MARGIN;
                 x++) begin
                a = y * hough_pkg::IMAGE_WIDTH + x;
                if (edge_mem[a] != 8'h00 && mask_mem[a] >= hough_pkg::MASK_MIN) begin
                    for (int t = 0; t < hough_pkg::THETA_COUNT; t++) begin
                        product = x * int'(hough_pkg::COS_TABLE[t]) + y * int'(hough_pkg::SIN_TABLE[t]);
                        // Arithmetic shift floors negative rho values
                        rho = (product >>> hough_pkg::TRIG_FRAC_BITS) + hough_pkg::RHO_OFFSET;
                        if (votes[t][rho] < COUNT_MAX) begin
                            votes[t][rho]++;
                        end
                    end
                end
            end
        end
        ln = 0;
        rn = 0;
        lr = 0;
        rr = 0;
        lt = 0;
        rt = 0;
        foreach (votes[t, b]) begin
            theta = t * hough_pkg::THETA_STEP_DEG;
            if (votes[t][b] >= hough_pkg::VOTE_THRESHOLD) begin
                if (theta > hough_pkg::LEFT_MIN_DEG) begin
                    ln++;
                    lr += b - hough_pkg::RHO_OFFSET;
                    lt += theta;
                end else if (theta < hough_pkg::RIGHT_MAX_DEG) begin
                    rn++;
                    rr += b - hough_pkg::RHO_OFFSET;
                    rt += theta;
                end
            end
        end
        left_n = hough_pkg::line_count_t'(ln);
        right_n = hough_pkg::line_count_t'(rn);
        left_rho = hough_pkg::rho_sum_t'(lr);
        right_rho = hough_pkg::rho_sum_t'(rr);
        left_theta = hough_pkg::theta_sum_t'(lt);
        right_theta = hough_pkg::theta_sum_t'(rt);
    endtask

`endif

// File: testbench/hough_tb.sv
`timescale 1ns/1ns

module hough_tb;

    logic clock;
    logic reset;
    logic start;
    hough_pkg::pixel_addr_t pixel_addr;
    logic [7:0] edge_data;
    logic [7:0] mask_data;
    logic done;
    hough_pkg::line_count_t left_count;
    hough_pkg::line_count_t right_count;
    hough_pkg::rho_sum_t left_rho_sum;
    hough_pkg::rho_sum_t right_rho_sum;
    hough_pkg::theta_sum_t left_theta_sum;
    hough_pkg::theta_sum_t right_theta_sum;

    // Host memories and the address they latched for the next answer
    logic [7:0] edge_mem [256];
    logic [7:0] mask_mem [256];
    hough_pkg::pixel_addr_t read_addr;
    int done_seen = 0;
    int error_count = 0;
    int checks_run = 0;
    int cycle_count = 0;

    `include "tb_frames.svh"

    // Worst-case frame is well under 256 pixels at five cycles plus the sweep
    localparam int TIMEOUT_CYCLES = FRAME_ROWS * (256 * 5 + 300);

    clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    hough_lane_finder hough_lane_finder_inst (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .pixel_addr      (pixel_addr),
        .edge_data       (edge_data),
        .mask_data       (mask_data),
        .done            (done),
        .left_count      (left_count),
        .right_count     (right_count),
        .left_rho_sum    (left_rho_sum),
        .right_rho_sum   (right_rho_sum),
        .left_theta_sum  (left_theta_sum),
        .right_theta_sum (right_theta_sum)
    );

    // The address seen in one cycle is answered 5 ns into the next
    initial begin
        edge_data = 8'h00;
        mask_data = 8'h00;
        forever begin
            @(negedge clock);
            read_addr = pixel_addr;
            @(posedge clock);
            #5;
            edge_data = edge_mem[read_addr];
            mask_data = mask_mem[read_addr];
        end
    end

    always @(negedge clock) begin
        if (done) begin
            done_seen++;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: done never came within %0d cycles, %0d errors before that",
                 TIMEOUT_CYCLES, error_count);
        $display("Something failed");
        $finish;
    end

    task automatic compare_line_count(input string what, input hough_pkg::line_count_t got,
                                      input hough_pkg::line_count_t expected);
        checks_run++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic verify_rho_sum(input string what, input hough_pkg::rho_sum_t got,
                                  input hough_pkg::rho_sum_t expected);
        checks_run++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic match_theta_sum(input string what, input hough_pkg::theta_sum_t got,
                                   input hough_pkg::theta_sum_t expected);
        checks_run++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic expect_done_pulses(input int expected);
        checks_run++;
        if (done_seen != expected) begin
            error_count++;
            $display("[FAIL] %0t ns: saw %0d done pulses, expected %0d", $time, done_seen, expected);
        end
    endtask

    task automatic compare_outputs(input string tag, input frame_row_t expected);
        compare_line_count({tag, " left count"}, left_count, expected.left_count);
        compare_line_count({tag, " right count"}, right_count, expected.right_count);
        verify_rho_sum({tag, " left rho sum"}, left_rho_sum, expected.left_rho);
        verify_rho_sum({tag, " right rho sum"}, right_rho_sum, expected.right_rho);
        match_theta_sum({tag, " left theta sum"}, left_theta_sum, expected.left_theta);
        match_theta_sum({tag, " right theta sum"}, right_theta_sum, expected.right_theta);
    endtask

    task automatic pulse_start();
        @(posedge clock);
        #5;
        start = 1'b1;
        @(posedge clock);
        #5;
        start = 1'b0;
    endtask

    initial begin : frame_loop
        frame_row_t row;
        frame_row_t expected;
        start = 1'b0;
        for (int a = 0; a < 256; a++) begin
            edge_mem[a] = 8'h00;
            mask_mem[a] = 8'h00;
        end
        @(negedge reset);
        // A start during the post-reset clear is dropped, and nothing changes
        pulse_start();
        repeat (hough_pkg::RHO_BINS * hough_pkg::STEPS_PER_LANE + 8) @(negedge clock);
        expected = frame_table[0];
        compare_outputs("idle", expected);
        expect_done_pulses(0);
        for (int r = 0; r < FRAME_ROWS; r++) begin
            row = frame_table[r];
            expected = row;
            if (row.kind != FRAME_REPEAT) begin
                build_frame(row);
            end
            if (row.use_model) begin
                model_frame(expected.left_count, expected.right_count, expected.left_rho,
                            expected.right_rho, expected.left_theta, expected.right_theta);
            end
            pulse_start();
            // A second start in the middle of the scan must not restart the frame
            repeat (10) @(posedge clock);
            pulse_start();
            @(negedge clock);
            while (!done) begin
                @(negedge clock);
            end
            compare_outputs($sformatf("frame %0d", r), expected);
            repeat (3) @(negedge clock);
            expect_done_pulses(r + 1);
        end
        $display("%0d checks, %0d errors", checks_run, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+testbench
source/hough_pkg.sv
source/vote_bus_if.sv
source/pixel_scanner.sv
source/vote_lane.sv
source/line_selector.sv
source/hough_lane_finder.sv
testbench/clock_gen.sv
testbench/hough_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= hough_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MESSAGE ?= Everything OK
SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MESSAGE)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
